/* files.f */
src/front_pkg.sv
src/operand_decode.sv
src/class_decode.sv
src/issue_merge.sv
src/shader_front.sv
sim/tb_clock_gen.sv
sim/tb_shader_front.sv

/* run.sh */
#!/bin/sh
# Build and run the shader front testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
	--top-module tb_shader_front -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_shader_front > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
	exit 1
fi
exit 0

/* sim/tb_shader_front.sv */
module tb_shader_front
import front_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 5;
	localparam int RANDOM_ITEMS = 300;
	localparam int TOTAL_ITEMS = 8 + 8 + 8 + RANDOM_ITEMS;
	localparam int TIMEOUT_NS = (4 * TOTAL_ITEMS + RESET_CYCLES) * CLK_PERIOD;
	localparam int STALL_LEN = 1024;
	localparam int DRAIN_CYCLES = 8;

	logic clk, rst_n;
	logic in_valid, in_ready, out_valid, out_ready;
	front_wave_t in_wave;
	issue_pkt_t out_pkt;

	int seed = 42;
	int cycle = 0;
	int checks_passed = 0;
	int checks_failed = 0;
	int main_passed = 0;
	int main_failed = 0;
	logic check_latency = 0;
	logic random_stall = 0;
	logic stall_pat [STALL_LEN];
	issue_pkt_t exp_q [$];
	int cyc_q [$];
	logic was_stalled = 0;
	issue_pkt_t held_pkt;

	tb_clock_gen u_clock (
		.clk,
		.rst_n
	);

	shader_front i_dut (
		.clk,
		.rst_n,
		.in_valid,
		.in_ready,
		.in_wave,
		.out_valid,
		.out_ready,
		.out_pkt
	);

	// Packet the front end should produce for one input word
	function automatic issue_pkt_t expected_pkt(input front_wave_t w);
		issue_pkt_t p;
		logic [1:0] cls;
		logic [2:0] op;
		logic [1:0] mode;
		logic rev;

		cls = w.insn.insn_class;
		op = w.insn.fpint_op;
		mode = w.insn.reg_mode;
		rev = w.insn.reg_rev;
		p = '0;
		p.group = w.group;
		p.retry = w.retry;
		p.reg_read.a_num = w.insn.ra;
		p.reg_read.b_num = w.insn.rb;
		p.reg_read.b_imm = w.insn.imm;
		p.reg_read.b_is_imm = w.insn.b_is_imm;
		p.reg_read.b_is_const = w.insn.b_from_consts;
		p.reg_read.scalar_rev = rev;
		case (mode)
			2'd0, 2'd2: begin // SVS, VVS
				p.reg_read.a_scalar = rev;
				p.reg_read.b_scalar = ~rev;
			end
			2'd1: begin
				p.reg_read.a_scalar = 1;
				p.reg_read.b_scalar = 1;
			end
			default: begin
				p.reg_read.a_scalar = 0;
				p.reg_read.b_scalar = 0;
			end
		endcase
		p.dest.num = w.insn.rd;
		p.dest.scalar = (mode == 2'd0) || (mode == 2'd1);
		if (!w.retry) begin
			p.dispatch.p1 = cls == 2'd1;
			p.dispatch.p2 = cls == 2'd2;
			p.dispatch.p3 = cls == 2'd3;
			p.writeback = cls == 2'd0;
		end
		case (op)
			3'd0: p.fpint_ctrl = 8'b0101_1001;
			3'd1: p.fpint_ctrl = 8'b1010_1001;
			3'd2: p.fpint_ctrl = 8'b0001_1000;
			3'd3: p.fpint_ctrl = 8'b0100_1001;
			3'd4: p.fpint_ctrl = 8'b0100_0000;
			3'd5: p.fpint_ctrl = 8'b0100_0100; // FMAX with swap
			3'd6: p.fpint_ctrl = 8'b0101_1011;
			default: p.fpint_ctrl = 8'b0000_0000;
		endcase
		return p;
	endfunction

	// Group and low operand fields come from rnd
	function automatic front_wave_t make_wave(input logic retry, input logic [1:0] cls,
			input logic [2:0] op, input logic [1:0] mode, input logic rev,
			input logic [31:0] rnd);
		return front_wave_t'({rnd[27:24], retry, cls, op, mode, rev, rnd[23:0]});
	endfunction

	function automatic int total_fails();
		return checks_failed + main_failed;
	endfunction

	task automatic check_field(input string name, input logic [63:0] want,
			input logic [63:0] got);
		assert (got === want) checks_passed++;
		else begin
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, want, got);
			checks_failed++;
		end
	endtask

	task automatic finish_test(input int num, input string name, input int fails_before);
		if (total_fails() == fails_before)
			$display("Test %0d (%s): ok", num, name);
		else
			$display("Test %0d (%s): %0d failed checks", num, name,
				total_fails() - fails_before);
	endtask

	// Hold the word until the DUT takes it
	task automatic send_item(input front_wave_t w, input int gap);
		repeat (gap) begin
			@(negedge clk);
			in_valid = 0;
		end
		@(negedge clk);
		in_valid = 1;
		in_wave = w;
		do
			@(posedge clk);
		while (!in_ready);
	endtask

	task automatic wait_drain();
		int n;

		n = 0;
		@(negedge clk);
		in_valid = 0;
		while ((exp_q.size() != 0 || out_valid) && n < DRAIN_CYCLES) begin
			@(negedge clk);
			n++;
		end
	endtask

	// Scoreboard and compare on the DUT's own edge
	always @(posedge clk) begin : scoreboard
		issue_pkt_t want;
		int in_cycle;
		int held;

		if (rst_n) begin
			held = exp_q.size();
			assert (held <= 2) checks_passed++;
			else begin
				$display("Error at %0t ns: %0d items held, more than two stages", $time, held);
				checks_failed++;
			end
			check_field("in_ready", 64'(!(held == 2 && !out_ready)), 64'(in_ready));

			if (was_stalled) begin
				check_field("out_valid", 64'(1), 64'(out_valid));
				check_field("out_pkt", 64'(held_pkt), 64'(out_pkt));
			end

			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("Error at %0t ns: DUT sent a packet with no input behind it",
						$time);
					checks_failed++;
				end else begin
					want = exp_q.pop_front();
					in_cycle = cyc_q.pop_front();
					check_field("out_pkt.group", 64'(want.group), 64'(out_pkt.group));
					check_field("out_pkt.retry", 64'(want.retry), 64'(out_pkt.retry));
					check_field("out_pkt.reg_read", 64'(want.reg_read), 64'(out_pkt.reg_read));
					check_field("out_pkt.dest", 64'(want.dest), 64'(out_pkt.dest));
					check_field("out_pkt.dispatch", 64'(want.dispatch), 64'(out_pkt.dispatch));
					check_field("out_pkt.fpint_ctrl", 64'(want.fpint_ctrl),
						64'(out_pkt.fpint_ctrl));
					check_field("out_pkt.writeback", 64'(want.writeback),
						64'(out_pkt.writeback));
					if (check_latency)
						check_field("handshake latency", 64'(2), 64'(cycle - in_cycle));
				end
			end

			if (in_valid && in_ready) begin
				exp_q.push_back(expected_pkt(in_wave));
				cyc_q.push_back(cycle);
			end
			was_stalled = out_valid && !out_ready;
			held_pkt = out_pkt;
		end
		cycle++;
	end

	initial begin : stall_gen
		int idx;

		idx = 0;
		out_ready = 1;
		forever begin
			@(negedge clk);
			if (random_stall) begin
				out_ready = stall_pat[idx % STALL_LEN];
				idx++;
			end else
				out_ready = 1;
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout: run went past %0d ns without finishing", TIMEOUT_NS);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : main
		front_wave_t waves [RANDOM_ITEMS];
		int gaps [RANDOM_ITEMS];
		logic [31:0] r1, r2;
		int fails_before;

		in_valid = 0;
		in_wave = '0;
		@(posedge rst_n);
		@(negedge clk);

		fails_before = total_fails();
		assert (out_valid === 1'b0 && in_ready === 1'b1) main_passed++;
		else begin
			$display("Fail at %0t ns: out_valid/in_ready expected 0/1, got %b/%b",
				$time, out_valid, in_ready);
			main_failed++;
		end
		finish_test(1, "after reset", fails_before);

		// Back to back so two items are in flight
		fails_before = total_fails();
		check_latency = 1;
		for (int op = 0; op < 8; op++) begin
			r1 = $random(seed);
			send_item(make_wave(1'b0, 2'd0, 3'(op), r1[29:28], r1[30], r1), 0);
		end
		wait_drain();
		check_latency = 0;
		finish_test(2, "FP/INT table", fails_before);

		fails_before = total_fails();
		for (int c = 0; c < 8; c++) begin
			r1 = $random(seed);
			send_item(make_wave(1'(c % 2), 2'(c / 2), r1[31:29], r1[28:27], r1[26], r1), 0);
		end
		wait_drain();
		finish_test(3, "classes and retry", fails_before);

		fails_before = total_fails();
		for (int m = 0; m < 8; m++) begin
			r1 = $random(seed);
			send_item(make_wave(r1[31], r1[30:29], r1[28:26], 2'(m / 2), 1'(m % 2), r1), 0);
		end
		wait_drain();
		finish_test(4, "register modes", fails_before);

		fails_before = total_fails();
		for (int i = 0; i < RANDOM_ITEMS; i++) begin
			r1 = $random(seed);
			r2 = $random(seed);
			waves[i] = front_wave_t'({r1[4:0], r2});
			gaps[i] = (r1[7:5] == 3'd0) ? int'(r1[9:8]) + 1 : 0;
		end
		for (int i = 0; i < STALL_LEN; i++) begin
			r1 = $random(seed);
			stall_pat[i] = r1[1:0] != 2'd0; // out_ready low one cycle in four
		end
		@(posedge clk);
		random_stall = 1;
		for (int i = 0; i < RANDOM_ITEMS; i++)
			send_item(waves[i], gaps[i]);
		random_stall = 0;
		wait_drain();
		finish_test(5, "back-pressure", fails_before);

		if (exp_q.size() != 0) begin
			$display("Error: %0d expected packets never came out", exp_q.size());
			main_failed++;
		end
		$display("Checks passed: %0d, failed: %0d", checks_passed + main_passed, total_fails());
		if (total_fails() == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALF_PERIOD = 5;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst_n = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1; // Released away from the active edge
	end

endmodule

/* src/shader_front.sv */
module shader_front
import front_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        in_valid,
	output logic        in_ready,
	input  front_wave_t in_wave,

	output logic        out_valid,
	input  logic        out_ready,
	output issue_pkt_t  out_pkt
);

	logic advance, retry, writeback;
	logic [GROUP_BITS-1:0] group;
	reg_read_t reg_read;
	dest_t dest;
	dispatch_t dispatch;
	fpint_ctrl_t fpint_ctrl;

	operand_decode u_operand (
		.clk,
		.advance,
		.insn(in_wave.insn),
		.reg_read,
		.dest
	);

	class_decode u_class (
		.clk,
		.rst_n,
		.advance,
		.wave(in_wave),
		.group,
		.retry,
		.dispatch,
		.fpint_ctrl,
		.writeback
	);

	issue_merge u_merge (
		.clk,
		.rst_n,
		.in_valid,
		.in_ready,
		.advance,
		.reg_read,
		.dest,
		.group,
		.retry,
		.dispatch,
		.fpint_ctrl,
		.writeback,
		.out_valid,
		.out_ready,
		.out_pkt
	);

endmodule

/* src/issue_merge.sv */
module issue_merge
import front_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  in_valid,
	output logic                  in_ready,
	output logic                  advance,

	input  reg_read_t             reg_read,
	input  dest_t                 dest,
	input  logic [GROUP_BITS-1:0] group,
	input  logic                  retry,
	input  dispatch_t             dispatch,
	input  fpint_ctrl_t           fpint_ctrl,
	input  logic                  writeback,

	output logic                  out_valid,
	input  logic                  out_ready,
	output issue_pkt_t            out_pkt
);

	logic s1_valid, s2_valid, move;

	// Stage 1 sits in the decoder registers, stage 2 in out_pkt
	assign move = s1_valid & (~s2_valid | out_ready);

	assign in_ready = ~s1_valid | ~s2_valid | out_ready;
	assign advance = in_valid & in_ready;
	assign out_valid = s2_valid;

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n) begin
			s1_valid <= 0;
			s2_valid <= 0;
		end else begin
			if (advance)
				s1_valid <= 1;
			else if (move)
				s1_valid <= 0;

			if (move)
				s2_valid <= 1;
			else if (out_ready)
				s2_valid <= 0; // Drained
		end

	// Held while stalled, since move stays low
	always_ff @(posedge clk)
		if (move) begin
			out_pkt.group <= group;
			out_pkt.retry <= retry;
			out_pkt.reg_read <= reg_read;
			out_pkt.dest <= dest;
			out_pkt.dispatch <= dispatch;
			out_pkt.fpint_ctrl <= fpint_ctrl;
			out_pkt.writeback <= writeback;
		end

endmodule

/* src/class_decode.sv */
module class_decode
import front_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  advance,
	input  front_wave_t           wave,

	output logic [GROUP_BITS-1:0] group,
	output logic                  retry,
	output dispatch_t             dispatch,
	output fpint_ctrl_t           fpint_ctrl,
	output logic                  writeback
);

	dispatch_t dispatch_next;
	fpint_ctrl_t ctrl_next;
	logic writeback_next;

	// Port flags and writeback from the instruction class
	always_comb begin
		dispatch_next = '0;
		writeback_next = 0;

		unique case (wave.insn.insn_class)
			FPINT: writeback_next = 1; // Port 0 takes no handshake
			MEM:   dispatch_next.p1 = 1;
			SFU:   dispatch_next.p2 = 1;
			GROUP: dispatch_next.p3 = 1;
		endcase

		// Retried words go nowhere
		if (wave.retry) begin
			dispatch_next = '0;
			writeback_next = 0;
		end
	end

	/* FP/INT datapath control, decoded regardless of class.
	   Bit order: mul_float unit_b put_mul zero_flags
	   minmax_abs minmax_swap int_signed round_enable */
	always_comb begin
		ctrl_next = '0;

		case (wave.insn.fpint_op)
			MOV:
				ctrl_next = 8'b0101_1001;

			FMUL:
				ctrl_next = 8'b1010_1001;

			IMUL:
				ctrl_next = 8'b0001_1000; // No rounding on integer product

			FADD:
				ctrl_next = 8'b0100_1001;

			FMAX, FMIN: begin
				ctrl_next = 8'b0100_0000;
				ctrl_next.minmax_swap = wave.insn.fpint_op == FMIN;
			end

			FCVT:
				ctrl_next = 8'b0101_1011;

			default:
				ctrl_next = '0; // Reserved
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n) begin
			dispatch <= '0;
			writeback <= 0;
		end else if (advance) begin
			dispatch <= dispatch_next;
			writeback <= writeback_next;
		end

	always_ff @(posedge clk)
		if (advance) begin
			group <= wave.group;
			retry <= wave.retry;
			fpint_ctrl <= ctrl_next;
		end

endmodule

/* src/operand_decode.sv */
module operand_decode
import front_pkg::*;
(
	input  logic       clk,
	input  logic       advance,
	input  insn_word_t insn,

	output reg_read_t  reg_read,
	output dest_t      dest
);

	logic a_scalar, b_scalar, dest_scalar;

	// Scalar/vector selection per register mode
	always_comb begin
		a_scalar = 0;
		b_scalar = 0;
		dest_scalar = 0;

		unique case (insn.reg_mode)
			SVS, VVS: begin
				a_scalar = insn.reg_rev; // reg_rev swaps which source is scalar
				b_scalar = ~insn.reg_rev;
			end

			SSS: begin
				a_scalar = 1;
				b_scalar = 1;
			end

			VVV: begin
				a_scalar = 0;
				b_scalar = 0;
			end
		endcase

		unique case (insn.reg_mode)
			SVS, SSS: dest_scalar = 1;
			VVS, VVV: dest_scalar = 0;
		endcase
	end

	always_ff @(posedge clk)
		if (advance) begin
			reg_read.a_num <= insn.ra;
			reg_read.b_num <= insn.rb;
			reg_read.b_imm <= insn.imm;
			reg_read.b_is_imm <= insn.b_is_imm;
			reg_read.b_is_const <= insn.b_from_consts;
			reg_read.scalar_rev <= insn.reg_rev;

			reg_read.a_scalar <= a_scalar;
			reg_read.b_scalar <= b_scalar;

			dest.num <= insn.rd;
			dest.scalar <= dest_scalar;
		end

endmodule

/* src/front_pkg.sv */
package front_pkg;

	localparam int INSN_BITS  = 32;
	localparam int GROUP_BITS = 4;
	localparam int REG_BITS   = 5;
	// What is left of the word after the fixed fields
	localparam int IMM_BITS   = INSN_BITS - 10 - 3 * REG_BITS;

	typedef enum logic [1:0] {
		FPINT = 2'd0,
		MEM   = 2'd1,
		SFU   = 2'd2,
		GROUP = 2'd3
	} insn_class_e;

	// Code 7 reserved
	typedef enum logic [2:0] {
		MOV  = 3'd0,
		FMUL = 3'd1,
		IMUL = 3'd2,
		FADD = 3'd3,
		FMAX = 3'd4,
		FMIN = 3'd5,
		FCVT = 3'd6
	} fpint_opcode_e;

	typedef enum logic [1:0] {
		SVS = 2'd0,
		SSS = 2'd1,
		VVS = 2'd2,
		VVV = 2'd3
	} reg_mode_e;

	typedef struct packed {
		insn_class_e         insn_class;
		fpint_opcode_e       fpint_op;
		reg_mode_e           reg_mode;
		logic                reg_rev;
		logic                b_is_imm;
		logic                b_from_consts;
		logic [REG_BITS-1:0] rd;
		logic [REG_BITS-1:0] ra;
		logic [REG_BITS-1:0] rb;
		logic [IMM_BITS-1:0] imm;
	} insn_word_t;

	typedef struct packed {
		logic [GROUP_BITS-1:0] group;
		logic                  retry;
		insn_word_t            insn;
	} front_wave_t;

	typedef struct packed {
		logic [REG_BITS-1:0] a_num;
		logic [REG_BITS-1:0] b_num;
		logic [IMM_BITS-1:0] b_imm;
		logic                b_is_imm;
		logic                b_is_const;
		logic                a_scalar;
		logic                b_scalar;
		logic                scalar_rev;
	} reg_read_t;

	typedef struct packed {
		logic [REG_BITS-1:0] num;
		logic                scalar;
	} dest_t;

	typedef struct packed {
		logic p1; // Memory
		logic p2; // Special function
		logic p3; // Group op
	} dispatch_t;

	typedef struct packed {
		logic mul_float;
		logic unit_b;
		logic put_mul;
		logic zero_flags;
		logic minmax_abs;
		logic minmax_swap;
		logic int_signed;
		logic round_enable;
	} fpint_ctrl_t;

	typedef struct packed {
		logic [GROUP_BITS-1:0] group;
		logic                  retry;
		reg_read_t             reg_read;
		dest_t                 dest;
		dispatch_t             dispatch;
		fpint_ctrl_t           fpint_ctrl;
		logic                  writeback;
	} issue_pkt_t;

endpackage
